// ==== Makefile ====
# Verilator build and run of the core testbench.

VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/tb_core.sv ====
// Testbench for the five-stage core
// Assembles small programs into instruction and data memory models,
// then checks every store and the final data memory against an
// ISA-level reference model.

`timescale 1ns/100ps
`include "core_consts.svh"

module tb_core;

	logic                  i_clk;
	logic                  i_arst_n;
	logic [`CORE_XLEN-1:0] i_read_instruction;
	logic [`CORE_XLEN-1:0] i_read_data;
	logic [`CORE_XLEN-1:0] o_instruction_address;
	logic [`CORE_XLEN-1:0] o_data_address;
	logic [`CORE_XLEN-1:0] o_write_data;
	logic                  o_mem_write;
	logic                  o_mem_read;

	logic [31:0] prog [256];     // program being assembled.
	logic [31:0] imem [256];
	logic [31:0] dmem [256];
	logic [31:0] ref_dmem [256];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic [31:0] exp_load [$];
	logic [31:0] halt_pc;
	logic [31:0] first_sw_pc;
	logic [31:0] wr_val;
	logic [7:0]  wr_idx;
	logic        wr_pend;
	logic [5:0]  fns [5];
	integer      seed;
	int          plen;
	int          n_seen;
	int          n_loads;
	int          cycle;
	int          first_fetch;
	int          errors;
	int          timeouts;

	core i_core (.i_clk(i_clk), .i_arst_n(i_arst_n), .i_read_instruction(i_read_instruction),
		.i_read_data(i_read_data), .o_instruction_address(o_instruction_address),
		.o_data_address(o_data_address), .o_write_data(o_write_data),
		.o_mem_write(o_mem_write), .o_mem_read(o_mem_read));

	assign i_read_instruction = imem[o_instruction_address[9:2]];
	assign i_read_data        = dmem[o_data_address[9:2]];

	initial begin
		i_clk = 1'b0;
		forever #20 i_clk = ~i_clk;
	end

	function automatic logic [31:0] r_type(input logic [5:0] fn, input int rd, input int rs,
		input int rt);
		return {6'h00, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
	endfunction

	function automatic logic [31:0] i_type(input logic [5:0] op, input int rt, input int rs,
		input int imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	function automatic void emit(input logic [31:0] w);
		prog[plen] = w;
		plen++;
	endfunction

	// producers and branches get three nops behind them.
	function automatic void emit_padded(input logic [31:0] w);
		emit(w);
		for (int k = 0; k < 3; k++) begin
			emit(32'h0);
		end
	endfunction

	function automatic void new_program();
		for (int i = 0; i < 256; i++) begin
			prog[i] = 32'h0;
		end
		plen = 0;
	endfunction

	function automatic void end_program();
		halt_pc = plen * 4;
		emit(i_type(core_pkg::OP_BEQ, 0, 0, -1)); // beq r0 to itself.
		first_sw_pc = halt_pc;
		for (int i = plen - 1; i >= 0; i--) begin
			if (prog[i][31:26] == core_pkg::OP_SW) begin
				first_sw_pc = i * 4;
			end
		end
	endfunction

	// ISA-level model, with the three slots after a beq always executed.
	function automatic void run_reference();
		logic [31:0] regs [32];
		logic [31:0] pc;
		logic [31:0] next;
		logic [31:0] target;
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] addr;
		int          slots;
		for (int i = 0; i < 32; i++) begin
			regs[i] = 32'h0;
		end
		exp_addr.delete();
		exp_data.delete();
		exp_load.delete();
		ref_dmem = dmem;
		pc       = `CORE_RESET_PC;
		target   = 32'h0;
		slots    = 0;
		for (int steps = 0; steps < 4000 && pc != halt_pc; steps++) begin
			w    = prog[pc[9:2]];
			a    = regs[w[25:21]];
			b    = regs[w[20:16]];
			imm  = {{16{w[15]}}, w[15:0]};
			addr = a + imm;
			next = pc + 32'd4;
			if (slots > 0) begin
				slots--;
				if (slots == 0) begin
					next = target;
				end
			end
			case (w[31:26])
				core_pkg::OP_RTYPE: begin
					case (w[5:0])
						core_pkg::FN_SUB: regs[w[15:11]] = a - b;
						core_pkg::FN_AND: regs[w[15:11]] = a & b;
						core_pkg::FN_OR:  regs[w[15:11]] = a | b;
						core_pkg::FN_SLT: regs[w[15:11]] =
							($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default:          regs[w[15:11]] = a + b;
					endcase
				end
				core_pkg::OP_ADDI: regs[w[20:16]] = addr;
				core_pkg::OP_LW: begin
					regs[w[20:16]] = ref_dmem[addr[9:2]];
					exp_load.push_back(addr);
				end
				core_pkg::OP_SW: begin
					ref_dmem[addr[9:2]] = b;
					exp_addr.push_back(addr);
					exp_data.push_back(b);
				end
				core_pkg::OP_BEQ: begin
					if (a == b) begin
						target = pc + 32'd4 + (imm << 2);
						slots  = 3;
					end
				end
				default: ;
			endcase
			regs[0] = 32'h0;
			pc      = next;
		end
	endfunction

	function automatic void alu_program();
		new_program();
		emit_padded(i_type(core_pkg::OP_ADDI, 1, 0, $random(seed)));
		emit_padded(i_type(core_pkg::OP_ADDI, 2, 0, $random(seed)));
		for (int k = 0; k < 5; k++) begin
			emit_padded(r_type(fns[k], 3 + k, 1, 2));
			emit(i_type(core_pkg::OP_SW, 3 + k, 0, 4 * k));
		end
		emit_padded(r_type(core_pkg::FN_SLT, 8, 2, 1)); // operands swapped.
		emit(i_type(core_pkg::OP_SW, 8, 0, 20));
		end_program();
	endfunction

	function automatic void memory_program();
		new_program();
		emit_padded(i_type(core_pkg::OP_ADDI, 1, 0, $random(seed)));
		emit_padded(i_type(core_pkg::OP_ADDI, 2, 0, $random(seed)));
		emit_padded(i_type(core_pkg::OP_ADDI, 8, 0, 32'h40)); // base register.
		emit(i_type(core_pkg::OP_SW, 1, 0, 32'h40));
		emit(i_type(core_pkg::OP_SW, 2, 8, 4));
		emit_padded(i_type(core_pkg::OP_LW, 3, 0, 32'h40));
		emit_padded(i_type(core_pkg::OP_LW, 4, 8, 4));
		emit_padded(i_type(core_pkg::OP_LW, 5, 0, 32'h80)); // untouched word, reads the fill.
		emit_padded(r_type(core_pkg::FN_ADD, 6, 3, 4));
		emit(i_type(core_pkg::OP_SW, 6, 8, 8));
		emit_padded(r_type(core_pkg::FN_SUB, 7, 5, 1));
		emit(i_type(core_pkg::OP_SW, 7, 8, 12));
		end_program();
	endfunction

	function automatic void branch_program();
		new_program();
		emit_padded(i_type(core_pkg::OP_ADDI, 1, 0, 5));
		emit_padded(i_type(core_pkg::OP_ADDI, 2, 0, 5));
		emit_padded(i_type(core_pkg::OP_ADDI, 3, 0, 7));
		emit_padded(i_type(core_pkg::OP_BEQ, 3, 1, 4)); // not taken.
		emit(i_type(core_pkg::OP_SW, 3, 0, 32'h20));
		emit_padded(i_type(core_pkg::OP_BEQ, 2, 1, 4)); // taken, skips the next store.
		emit(i_type(core_pkg::OP_SW, 3, 0, 32'h24));
		emit(i_type(core_pkg::OP_SW, 2, 0, 32'h28));
		end_program();
	endfunction

	function automatic void random_program();
		int rnd;
		int d;
		new_program();
		for (int r = 1; r < 8; r++) begin
			emit_padded(i_type(core_pkg::OP_ADDI, r, 0, $random(seed)));
		end
		for (int k = 0; k < 12; k++) begin
			rnd = $random(seed);
			d   = (k == 0) ? 0 : (rnd & 7); // first result always aimed at r0.
			emit_padded(r_type(fns[((rnd >> 9) & 32'h7fff) % 5], d, (rnd >> 3) & 7,
				(rnd >> 6) & 7));
			emit(i_type(core_pkg::OP_SW, d, 0, 32'h100 + 4 * k));
		end
		end_program();
	endfunction

	task automatic run_program(input string name);
		int i;
		@(negedge i_clk);
		i_arst_n <= 1'b0;
		@(negedge i_clk);
		for (i = 0; i < 256; i++) begin
			imem[i] = prog[i];
			dmem[i] = 32'hd00d_0000 | (i << 2);
		end
		run_reference();
		n_seen      = 0;
		n_loads     = 0;
		first_fetch = -1;
		wr_pend     = 1'b0;
		repeat (3) @(negedge i_clk);
		i_arst_n <= 1'b1;
		for (i = 0; i < 1000 && o_instruction_address != halt_pc; i++) begin
			@(negedge i_clk);
		end
		if (o_instruction_address != halt_pc) begin
			$display("timeout: %s program never reached its final branch", name);
			timeouts++;
		end
		repeat (4) @(negedge i_clk); // older instructions have left the pipeline.
		if (n_seen != exp_addr.size()) begin
			$display("Fail at %0t: %s program made %0d stores, expected %0d", $time, name,
				n_seen, exp_addr.size());
			errors++;
		end
		if (n_loads != exp_load.size()) begin
			$display("Fail at %0t: %s program made %0d loads, expected %0d", $time, name,
				n_loads, exp_load.size());
			errors++;
		end
		for (i = 0; i < 256; i++) begin
			if (dmem[i] != ref_dmem[i]) begin
				$display("Fail at %0t: %s program left %h in word %0d, expected %h", $time,
					name, dmem[i], i, ref_dmem[i]);
				errors++;
			end
		end
	endtask

	// store and load checker, sampling where the DUT outputs are stable.
	always @(negedge i_clk) begin
		cycle++;
		if (!i_arst_n && (o_mem_write || o_mem_read ||
			o_instruction_address != `CORE_RESET_PC)) begin
			$display("Fail at %0t: memory strobe or pc not at reset value in reset", $time);
			errors++;
		end
		if (i_arst_n && first_fetch < 0 && o_instruction_address == first_sw_pc) begin
			first_fetch = cycle;
		end
		if (o_mem_read) begin
			if (n_loads >= exp_load.size()) begin
				$display("Fail at %0t: extra load from %h", $time, o_data_address);
				errors++;
			end else if (o_data_address != exp_load[n_loads]) begin
				$display("Fail at %0t: load %0d read %h, expected %h", $time, n_loads,
					o_data_address, exp_load[n_loads]);
				errors++;
			end
			n_loads++;
		end
		if (o_mem_write) begin
			if (n_seen == 0 && cycle != first_fetch + 3) begin
				$display("Fail at %0t: first store not three cycles after its fetch", $time);
				errors++;
			end
			if (n_seen >= exp_addr.size()) begin
				$display("Fail at %0t: extra store of %h to %h", $time, o_write_data,
					o_data_address);
				errors++;
			end else if (o_data_address != exp_addr[n_seen] ||
				o_write_data != exp_data[n_seen]) begin
				$display("Fail at %0t: store %0d wrote %h to %h, expected %h to %h", $time,
					n_seen, o_write_data, o_data_address, exp_data[n_seen], exp_addr[n_seen]);
				errors++;
			end
			wr_pend = 1'b1;
			wr_idx  = o_data_address[9:2];
			wr_val  = o_write_data;
			n_seen++;
		end
	end

	// data memory write lands on the rising edge.
	always @(posedge i_clk) begin
		if (wr_pend) begin
			dmem[wr_idx] = wr_val;
			wr_pend      = 1'b0;
		end
	end

	initial begin
		i_arst_n <= 1'b0;
		seed        = 32'h966b;
		errors      = 0;
		timeouts    = 0;
		n_seen      = 0;
		n_loads     = 0;
		cycle       = 0;
		first_fetch = -1;
		wr_pend     = 1'b0;
		halt_pc     = 32'h0;
		first_sw_pc = 32'h0;
		fns = '{core_pkg::FN_ADD, core_pkg::FN_SUB, core_pkg::FN_AND, core_pkg::FN_OR,
			core_pkg::FN_SLT};
		alu_program();
		run_program("alu");
		memory_program();
		run_program("load/store");
		branch_program();
		run_program("branch");
		for (int r = 0; r < 5; r++) begin
			random_program();
			run_program("random");
		end
		$display("errors: %0d  timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== design/core.sv ====
// Core top level
// Five-stage MIPS-subset pipeline. Chains fetch, decode, execute
// and mem, and presents the instruction and data memory ports.

`timescale 1ns/100ps
`include "core_consts.svh"

module core (
	input  logic                  i_clk,
	input  logic                  i_arst_n,
	input  logic [`CORE_XLEN-1:0] i_read_instruction,
	input  logic [`CORE_XLEN-1:0] i_read_data,
	output logic [`CORE_XLEN-1:0] o_instruction_address,
	output logic [`CORE_XLEN-1:0] o_data_address,
	output logic [`CORE_XLEN-1:0] o_write_data,
	output logic                  o_mem_write,
	output logic                  o_mem_read
);

	core_pkg::if_id_t  if_id;
	core_pkg::id_ex_t  id_ex;
	core_pkg::ex_mem_t ex_mem;
	core_pkg::mem_wb_t mem_wb;
	logic              pc_src;

	// data port straight from EX/MEM.
	assign o_data_address = ex_mem.alu_result;
	assign o_write_data   = ex_mem.rt_data;
	assign o_mem_write    = ex_mem.memwrite;
	assign o_mem_read     = ex_mem.memread;

	fetch u_fetch (
		.i_clk           (i_clk),
		.i_arst_n        (i_arst_n),
		.i_pc_src        (pc_src),
		.i_branch_target (ex_mem.branch_target),
		.i_instr         (i_read_instruction),
		.o_pc            (o_instruction_address),
		.o_if_id         (if_id)
	);

	decode u_decode (.i_clk(i_clk), .i_arst_n(i_arst_n), .i_if_id(if_id),
		.i_mem_wb(mem_wb), .o_id_ex(id_ex));

	execute u_execute (.i_clk(i_clk), .i_arst_n(i_arst_n), .i_id_ex(id_ex),
		.o_ex_mem(ex_mem));

	mem u_mem (.i_clk(i_clk), .i_arst_n(i_arst_n), .i_ex_mem(ex_mem),
		.i_read_data(i_read_data), .o_pc_src(pc_src), .o_mem_wb(mem_wb));

endmodule

// ==== design/core_consts.svh ====
// Core constants
// Widths, reset vector and the main-control ALU op codes
// shared by the MIPS-subset pipeline.

`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// datapath and address width.
`define CORE_XLEN 32

// register-number width.
`define CORE_RADDR_W 5

// pc value after reset.
`define CORE_RESET_PC 32'h0000_0000

// main-control alu op, decoded further in execute.
`define CORE_ALUOP_ADD 2'b00
`define CORE_ALUOP_SUB 2'b01
`define CORE_ALUOP_FUNCT 2'b10

`endif

// ==== design/core_pkg.sv ====
// Core package
// Opcode and function encodings, the control bundle and the
// four pipeline-register structs of the five-stage core.

`include "core_consts.svh"

package core_pkg;

	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_BEQ   = 6'h04,
		OP_ADDI  = 6'h08,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_e;

	// also used as the alu operation select.
	typedef enum logic [5:0] {
		FN_ADD = 6'h20,
		FN_SUB = 6'h22,
		FN_AND = 6'h24,
		FN_OR  = 6'h25,
		FN_SLT = 6'h2a
	} funct_e;

	typedef struct packed {
		logic       regdst;   // rd instead of rt.
		logic       alusrc;   // immediate operand.
		logic [1:0] aluop;
		logic       branch;
		logic       memread;
		logic       memwrite;
		logic       memtoreg;
		logic       regwrite;
	} ctrl_t;

	typedef struct packed {
		logic [`CORE_XLEN-1:0] instr;
		logic [`CORE_XLEN-1:0] next_pc;
	} if_id_t;

	typedef struct packed {
		ctrl_t                    ctrl;
		logic [`CORE_XLEN-1:0]    next_pc;
		logic [`CORE_XLEN-1:0]    rs_data;
		logic [`CORE_XLEN-1:0]    rt_data;
		logic [`CORE_XLEN-1:0]    imm;      // sign extended.
		logic [`CORE_RADDR_W-1:0] rt;
		logic [`CORE_RADDR_W-1:0] rd;
	} id_ex_t;

	typedef struct packed {
		logic                     branch;
		logic                     memread;
		logic                     memwrite;
		logic                     memtoreg;
		logic                     regwrite;
		logic [`CORE_XLEN-1:0]    branch_target;
		logic                     zero;
		logic [`CORE_XLEN-1:0]    alu_result;
		logic [`CORE_XLEN-1:0]    rt_data;
		logic [`CORE_RADDR_W-1:0] dst;
	} ex_mem_t;

	typedef struct packed {
		logic                     memtoreg;
		logic                     regwrite;
		logic [`CORE_XLEN-1:0]    read_data;
		logic [`CORE_XLEN-1:0]    alu_result;
		logic [`CORE_RADDR_W-1:0] dst;
	} mem_wb_t;

endpackage

// ==== design/decode.sv ====
// Decode stage
// Main control, the 32-entry register file with its write-back
// select and write-through, sign extension, and the ID/EX register.
// Register 0 is never written, so it always reads zero.

`timescale 1ns/100ps
`include "core_consts.svh"

module decode (
	input  logic               i_clk,
	input  logic               i_arst_n,
	input  core_pkg::if_id_t   i_if_id,
	input  core_pkg::mem_wb_t  i_mem_wb,
	output core_pkg::id_ex_t   o_id_ex
);

	localparam int NREGS = 1 << `CORE_RADDR_W;

	logic [5:0]               opcode;
	logic [`CORE_RADDR_W-1:0] rs;
	logic [`CORE_RADDR_W-1:0] rt;
	logic [`CORE_RADDR_W-1:0] rd;
	logic [`CORE_XLEN-1:0]    imm_ext;
	core_pkg::ctrl_t          ctrl;

	logic [`CORE_XLEN-1:0] rf [NREGS];
	logic                  wb_we;
	logic [`CORE_XLEN-1:0] wb_data;
	logic [`CORE_XLEN-1:0] rs_data;
	logic [`CORE_XLEN-1:0] rt_data;

	assign opcode  = i_if_id.instr[31:26];
	assign rs      = i_if_id.instr[25:21];
	assign rt      = i_if_id.instr[20:16];
	assign rd      = i_if_id.instr[15:11];
	assign imm_ext = {{(`CORE_XLEN-16){i_if_id.instr[15]}}, i_if_id.instr[15:0]};

	always_comb begin
		ctrl = '0;                          // unknown opcode does nothing.
		case (core_pkg::opcode_e'(opcode))
			core_pkg::OP_RTYPE: begin
				ctrl.regdst   = 1'b1;
				ctrl.aluop    = `CORE_ALUOP_FUNCT;
				ctrl.regwrite = 1'b1;
			end
			core_pkg::OP_ADDI: begin
				ctrl.alusrc   = 1'b1;
				ctrl.aluop    = `CORE_ALUOP_ADD;
				ctrl.regwrite = 1'b1;
			end
			core_pkg::OP_LW: begin
				ctrl.alusrc   = 1'b1;
				ctrl.aluop    = `CORE_ALUOP_ADD;
				ctrl.memread  = 1'b1;
				ctrl.memtoreg = 1'b1;
				ctrl.regwrite = 1'b1;
			end
			core_pkg::OP_SW: begin
				ctrl.alusrc   = 1'b1;
				ctrl.aluop    = `CORE_ALUOP_ADD;
				ctrl.memwrite = 1'b1;
			end
			core_pkg::OP_BEQ: begin
				ctrl.branch   = 1'b1;
				ctrl.aluop    = `CORE_ALUOP_SUB; // zero flag compares rs and rt.
			end
			default: ctrl = '0;
		endcase
	end

	// write-back select, folded into the write port.
	assign wb_data = i_mem_wb.memtoreg ? i_mem_wb.read_data : i_mem_wb.alu_result;
	assign wb_we   = i_mem_wb.regwrite && (i_mem_wb.dst != '0);

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int i = 0; i < NREGS; i++) begin
				rf[i] <= '0;
			end
		end else if (wb_we) begin
			rf[i_mem_wb.dst] <= wb_data;
		end
	end

	// write-through, so a reader in the write-back cycle sees the new value.
	assign rs_data = (wb_we && i_mem_wb.dst == rs) ? wb_data : rf[rs];
	assign rt_data = (wb_we && i_mem_wb.dst == rt) ? wb_data : rf[rt];

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_id_ex <= '0;
		end else begin
			o_id_ex.ctrl    <= ctrl;
			o_id_ex.next_pc <= i_if_id.next_pc;
			o_id_ex.rs_data <= rs_data;
			o_id_ex.rt_data <= rt_data;
			o_id_ex.imm     <= imm_ext;
			o_id_ex.rt      <= rt;
			o_id_ex.rd      <= rd;
		end
	end

	a_no_rw_both: assert property (
		@(posedge i_clk) disable iff (!i_arst_n)
		!(o_id_ex.ctrl.memread && o_id_ex.ctrl.memwrite)
	) else $error("decode: memread and memwrite both set");

	a_r0_zero: assert property (
		@(posedge i_clk) disable iff (!i_arst_n)
		rf[0] == '0
	) else $error("decode: register 0 was written");

endmodule

// ==== design/execute.sv ====
// Execute stage
// ALU control and ALU, branch-target adder, destination
// register select, and the EX/MEM register.

`timescale 1ns/100ps
`include "core_consts.svh"

module execute (
	input  logic               i_clk,
	input  logic               i_arst_n,
	input  core_pkg::id_ex_t   i_id_ex,
	output core_pkg::ex_mem_t  o_ex_mem
);

	core_pkg::funct_e         alu_fn;
	logic [`CORE_XLEN-1:0]    op_a;
	logic [`CORE_XLEN-1:0]    op_b;
	logic [`CORE_XLEN-1:0]    alu_result;
	logic [`CORE_XLEN-1:0]    branch_target;
	logic [`CORE_RADDR_W-1:0] dst;

	always_comb begin
		case (i_id_ex.ctrl.aluop)
			`CORE_ALUOP_SUB:   alu_fn = core_pkg::FN_SUB;
			`CORE_ALUOP_FUNCT: alu_fn = core_pkg::funct_e'(i_id_ex.imm[5:0]);
			default:           alu_fn = core_pkg::FN_ADD;
		endcase
	end

	assign op_a = i_id_ex.rs_data;
	assign op_b = i_id_ex.ctrl.alusrc ? i_id_ex.imm : i_id_ex.rt_data;

	always_comb begin
		case (alu_fn)
			core_pkg::FN_SUB: alu_result = op_a - op_b;
			core_pkg::FN_AND: alu_result = op_a & op_b;
			core_pkg::FN_OR:  alu_result = op_a | op_b;
			core_pkg::FN_SLT: alu_result = {{(`CORE_XLEN-1){1'b0}},
			                                ($signed(op_a) < $signed(op_b))};
			default:          alu_result = op_a + op_b; // add, and the nop funct.
		endcase
	end

	assign branch_target = i_id_ex.next_pc + {i_id_ex.imm[`CORE_XLEN-3:0], 2'b00};
	assign dst           = i_id_ex.ctrl.regdst ? i_id_ex.rd : i_id_ex.rt;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_ex_mem <= '0;
		end else begin
			o_ex_mem.branch        <= i_id_ex.ctrl.branch;
			o_ex_mem.memread       <= i_id_ex.ctrl.memread;
			o_ex_mem.memwrite      <= i_id_ex.ctrl.memwrite;
			o_ex_mem.memtoreg      <= i_id_ex.ctrl.memtoreg;
			o_ex_mem.regwrite      <= i_id_ex.ctrl.regwrite;
			o_ex_mem.branch_target <= branch_target;
			o_ex_mem.zero          <= (alu_result == '0);
			o_ex_mem.alu_result    <= alu_result;
			o_ex_mem.rt_data       <= i_id_ex.rt_data; // store data.
			o_ex_mem.dst           <= dst;
		end
	end

	a_aluop_known: assert property (
		@(posedge i_clk) disable iff (!i_arst_n)
		i_id_ex.ctrl.aluop inside {`CORE_ALUOP_ADD, `CORE_ALUOP_SUB, `CORE_ALUOP_FUNCT}
	) else $error("execute: unused aluop code from decode");

endmodule

// ==== design/fetch.sv ====
// Fetch stage
// Holds the program counter, steps it by four or takes the
// branch redirect from mem, and registers the fetched word into IF/ID.

`timescale 1ns/100ps
`include "core_consts.svh"

module fetch (
	input  logic                  i_clk,
	input  logic                  i_arst_n,
	input  logic                  i_pc_src,
	input  logic [`CORE_XLEN-1:0] i_branch_target,
	input  logic [`CORE_XLEN-1:0] i_instr,
	output logic [`CORE_XLEN-1:0] o_pc,
	output core_pkg::if_id_t      o_if_id
);

	logic [`CORE_XLEN-1:0] pc_plus4;
	logic [`CORE_XLEN-1:0] pc_next;

	assign pc_plus4 = o_pc + `CORE_XLEN'd4;
	assign pc_next  = i_pc_src ? i_branch_target : pc_plus4; // taken beq wins.

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_pc    <= `CORE_RESET_PC;
			o_if_id <= '0;                  // zero word is a nop.
		end else begin
			o_pc            <= pc_next;
			o_if_id.instr   <= i_instr;
			o_if_id.next_pc <= pc_plus4;
		end
	end

	// a misaligned target would mean a bad branch offset upstream.
	a_pc_aligned: assert property (
		@(posedge i_clk) disable iff (!i_arst_n)
		o_pc[1:0] == 2'b00
	) else $error("fetch: pc not word aligned");

endmodule

// ==== design/mem.sv ====
// Memory stage
// Branch decision for the fetch redirect, capture of the load
// data returned in the same cycle, and the MEM/WB register.

`timescale 1ns/100ps
`include "core_consts.svh"

module mem (
	input  logic                  i_clk,
	input  logic                  i_arst_n,
	input  core_pkg::ex_mem_t     i_ex_mem,
	input  logic [`CORE_XLEN-1:0] i_read_data,
	output logic                  o_pc_src,
	output core_pkg::mem_wb_t     o_mem_wb
);

	// beq taken when the subtract came out zero.
	assign o_pc_src = i_ex_mem.branch & i_ex_mem.zero;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_mem_wb <= '0;
		end else begin
			o_mem_wb.memtoreg   <= i_ex_mem.memtoreg;
			o_mem_wb.regwrite   <= i_ex_mem.regwrite;
			o_mem_wb.read_data  <= i_read_data;      // only meaningful for lw.
			o_mem_wb.alu_result <= i_ex_mem.alu_result;
			o_mem_wb.dst        <= i_ex_mem.dst;
		end
	end

endmodule

// ==== project.f ====
+incdir+design
design/core_pkg.sv
design/fetch.sv
design/decode.sv
design/execute.sv
design/mem.sv
design/core.sv
bench/tb_core.sv
